/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := pioStateMachine_tb
FILELIST  := verilog.f
RUN_FLAGS := +verilator+error+limit+10
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Test FAILED
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/pioCfgPkg.sv */
// Field positions inside the PIO configuration words
package pioCfgPkg;

    // execCtrl word
    localparam int jmpPinMsb     = 28;  // GPIO tested by JMP PIN
    localparam int jmpPinLsb     = 24;
    localparam int wrapTopMsb    = 16;  // Last address before wrapping
    localparam int wrapTopLsb    = 12;
    localparam int wrapBottomMsb = 11;  // Wrap destination
    localparam int wrapBottomLsb = 7;

    // shiftCtrl word
    localparam int outShiftRightBit = 19;
    localparam int inShiftRightBit  = 18;

    // clkDiv word, integer divisor only
    localparam int clkDivIntMsb = 31;
    localparam int clkDivIntLsb = 16;

endpackage

/* common/pioPkg.sv */
// PIO instruction encoding, opcode classes and data widths shared by all blocks
package pioPkg;

    typedef logic [31:0] word_t;       // Scratch, shift register, FIFO and pin data
    typedef logic [15:0] opcode_t;     // One program word
    typedef logic [4:0]  pcAddr_t;     // 32-entry program space
    typedef logic [4:0]  bitCount_t;   // Shift length, 0 encodes 32
    typedef logic [4:0]  delay_t;
    typedef logic [15:0] clkDivInt_t;  // Integer part of the clock divider

    // Instruction classes, bits 15..13 of the opcode
    typedef enum logic [2:0] {
        opJmp      = 3'd0,
        opWait     = 3'd1,
        opIn       = 3'd2,
        opOut      = 3'd3,
        opPushPull = 3'd4,
        opMov      = 3'd5,
        opIrq      = 3'd6,
        opSet      = 3'd7
    } instrOp_e;

    // Opcode field positions
    localparam int opMsb    = 15;
    localparam int opLsb    = 13;
    localparam int delayMsb = 12;
    localparam int delayLsb = 8;
    localparam int condMsb  = 7;   // Condition, source or destination
    localparam int condLsb  = 5;
    localparam int dataMsb  = 4;   // Bit count, index, address or immediate
    localparam int dataLsb  = 0;

    // Push and pull threshold, no longer configurable
    localparam int shiftFullCount = 32;

endpackage

/* design/clockDivider.sv */
// Integer clock divider issuing one execution tick every clkDivInt cycles
`timescale 1ns/1ps

module clockDivider import pioPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  clkDivInt_t clkDivInt,
    input  logic       restart,
    output logic       tick
);

    clkDivInt_t count;
    clkDivInt_t reloadValue;

    // Divisors 0 and 1 both tick every cycle
    assign reloadValue = (clkDivInt == '0) ? '0 : clkDivInt - 1'b1;

    // Restart suppresses the tick in its own cycle
    assign tick = (count == '0) && !restart;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count <= '0;
        end else if (restart) begin
            count <= reloadValue;  // Next tick clkDivInt cycles from now
        end else if (count == '0) begin
            count <= reloadValue;
        end else begin
            count <= count - 1'b1;
        end
    end

endmodule

/* design/executionUnit.sv */
// PIO execution unit with program counter, scratch registers, delay and instruction classes
`timescale 1ns/1ps

module executionUnit import pioPkg::*; import pioCfgPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      tick,
    input  logic      smEnable,
    input  opcode_t   opCode,
    input  word_t     execCtrl,
    input  word_t     gpioIn,
    input  word_t     txData,
    input  logic      txEmpty,
    input  logic      rxFull,
    input  word_t     isrData,
    input  logic      isrFull,
    input  word_t     osrData,
    input  logic      osrEmpty,
    output pcAddr_t   pc,
    output logic      txAck,
    output word_t     rxData,
    output logic      rxValid,
    output logic      pinWrite,
    output logic      pinIsDir,
    output word_t     pinData,
    output logic      isrShiftEn,
    output bitCount_t isrShiftLen,
    output word_t     isrShiftData,
    output logic      isrClear,
    output logic      osrShiftEn,
    output bitCount_t osrShiftLen,
    output logic      osrLoadEn,
    output word_t     osrLoadData
);

    instrOp_e   instrOp;
    delay_t     instrDelay;
    logic [2:0] instrCond;
    logic [4:0] instrData;
    logic [4:0] jmpPin;
    pcAddr_t    wrapTop;
    pcAddr_t    wrapBottom;
    pcAddr_t    seqPc;
    logic       execTick;

    word_t      scratchX;
    word_t      scratchY;
    delay_t     delayCnt;

    pcAddr_t    nextPc;
    word_t      nextX;
    word_t      nextY;
    delay_t     nextDelay;
    logic       nextPinWrite;
    logic       nextPinIsDir;
    word_t      nextPinData;
    logic       nextTxAck;
    logic       nextRxValid;
    logic       jmpTaken;
    logic       stall;        // Instruction did not complete this tick

    assign instrOp    = instrOp_e'(opCode[opMsb:opLsb]);
    assign instrDelay = opCode[delayMsb:delayLsb];
    assign instrCond  = opCode[condMsb:condLsb];
    assign instrData  = opCode[dataMsb:dataLsb];

    assign jmpPin     = execCtrl[jmpPinMsb:jmpPinLsb];
    assign wrapTop    = execCtrl[wrapTopMsb:wrapTopLsb];
    assign wrapBottom = execCtrl[wrapBottomMsb:wrapBottomLsb];

    assign seqPc    = (pc == wrapTop) ? wrapBottom : pc + 1'b1;
    assign execTick = tick && smEnable;

    // Shift length comes straight from the data field
    assign isrShiftLen = instrData;
    assign osrShiftLen = instrData;
    assign osrLoadData = txEmpty ? scratchX : txData;  // Non-blocking pull of empty FIFO loads X

    always_comb begin
        nextPc       = pc;
        nextX        = scratchX;
        nextY        = scratchY;
        nextDelay    = delayCnt;
        nextPinWrite = 1'b0;
        nextPinIsDir = 1'b0;
        nextPinData  = '0;
        nextTxAck    = 1'b0;
        nextRxValid  = 1'b0;
        jmpTaken     = 1'b0;
        stall        = 1'b0;
        isrShiftEn   = 1'b0;
        isrShiftData = '0;
        isrClear     = 1'b0;
        osrShiftEn   = 1'b0;
        osrLoadEn    = 1'b0;

        if (execTick && delayCnt != '0) begin
            nextDelay = delayCnt - 1'b1;  // Idle tick
        end else if (execTick) begin
            nextPc = seqPc;
            case (instrOp)
                opJmp: begin
                    case (instrCond)
                        3'b000: jmpTaken = 1'b1;
                        3'b001: jmpTaken = (scratchX == '0);
                        3'b010: begin
                            jmpTaken = (scratchX != '0);  // Tested before the decrement
                            nextX    = scratchX - 1'b1;
                        end
                        3'b011: jmpTaken = (scratchY == '0);
                        3'b100: begin
                            jmpTaken = (scratchY != '0);
                            nextY    = scratchY - 1'b1;
                        end
                        3'b101: jmpTaken = (scratchX != scratchY);
                        3'b110: jmpTaken = gpioIn[jmpPin];
                        default: jmpTaken = 1'b0;
                    endcase
                    if (jmpTaken) begin
                        nextPc = instrData;
                    end
                end
                opWait: begin
                    // Only the GPIO source waits, cond[2] is the polarity
                    if (instrCond[1:0] == 2'b00 && gpioIn[instrData] != instrCond[2]) begin
                        stall  = 1'b1;
                        nextPc = pc;
                    end
                end
                opIn: begin
                    isrShiftEn = 1'b1;
                    case (instrCond)
                        3'b000: isrShiftData = gpioIn;
                        3'b001: isrShiftData = scratchX;
                        3'b010: isrShiftData = scratchY;
                        default: isrShiftData = '0;  // Null
                    endcase
                end
                opOut: begin
                    osrShiftEn = 1'b1;
                    case (instrCond)
                        3'b000: begin
                            nextPinWrite = 1'b1;
                            nextPinData  = osrData;
                        end
                        3'b001: nextX = osrData;
                        3'b010: nextY = osrData;
                        3'b100: begin
                            nextPinWrite = 1'b1;
                            nextPinIsDir = 1'b1;
                            nextPinData  = osrData;
                        end
                        3'b101: nextPc = osrData[4:0];
                        default: nextPinWrite = 1'b0;  // Bits discarded
                    endcase
                end
                opPushPull: begin
                    // cond[2] pull, cond[1] iffull or ifempty, cond[0] block
                    if (instrCond[0] && (instrCond[2] ? txEmpty : rxFull)) begin
                        stall  = 1'b1;
                        nextPc = pc;
                    end else if (instrCond[2]) begin
                        if (!instrCond[1] || osrEmpty) begin
                            osrLoadEn = 1'b1;
                            nextTxAck = !txEmpty;
                        end
                    end else if (!instrCond[1] || isrFull) begin
                        isrClear    = 1'b1;
                        nextRxValid = !rxFull;  // Data dropped when the RX FIFO is full
                    end
                end
                opSet: begin
                    case (instrCond)
                        3'b000: begin
                            nextPinWrite = 1'b1;
                            nextPinData  = word_t'(instrData);
                        end
                        3'b001: nextX = word_t'(instrData);
                        3'b010: nextY = word_t'(instrData);
                        3'b100: begin
                            nextPinWrite = 1'b1;
                            nextPinIsDir = 1'b1;
                            nextPinData  = word_t'(instrData);
                        end
                        default: nextPinWrite = 1'b0;
                    endcase
                end
                opMov, opIrq: nextPc = seqPc;  // Not implemented, just advance
                default: nextPc = seqPc;
            endcase

            if (!stall) begin
                nextDelay = instrDelay;
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc       <= '0;
            scratchX <= '0;
            scratchY <= '0;
            delayCnt <= '0;
            pinWrite <= 1'b0;
            txAck    <= 1'b0;
            rxValid  <= 1'b0;
        end else begin
            pc       <= nextPc;
            scratchX <= nextX;
            scratchY <= nextY;
            delayCnt <= nextDelay;
            pinWrite <= nextPinWrite;
            txAck    <= nextTxAck;
            rxValid  <= nextRxValid;
        end
    end

    always_ff @(posedge clk) begin
        if (nextPinWrite) begin
            pinIsDir <= nextPinIsDir;
            pinData  <= nextPinData;
        end
        if (nextRxValid) begin
            rxData <= isrData;  // ISR contents before the clear
        end
    end

endmodule

/* design/pioStateMachine.sv */
// PIO state machine top joining divider, shift registers and execution unit
`timescale 1ns/1ps

module pioStateMachine import pioPkg::*; import pioCfgPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    smEnable,
    input  logic    clkDivRestart,
    input  word_t   clkDiv,
    input  word_t   execCtrl,
    input  word_t   shiftCtrl,
    input  opcode_t opCode,
    input  word_t   gpioIn,
    input  word_t   txData,
    input  logic    txEmpty,
    input  logic    rxFull,
    output pcAddr_t pc,
    output logic    txAck,
    output word_t   rxData,
    output logic    rxValid,
    output logic    pinWrite,
    output logic    pinIsDir,
    output word_t   pinData
);

    logic       tick;
    clkDivInt_t clkDivInt;
    logic       inShiftRight;
    logic       outShiftRight;

    logic       isrShiftEn;
    bitCount_t  isrShiftLen;
    word_t      isrShiftData;
    logic       isrClear;
    word_t      isrData;
    logic       isrFull;

    logic       osrShiftEn;
    bitCount_t  osrShiftLen;
    logic       osrLoadEn;
    word_t      osrLoadData;
    word_t      osrData;
    logic       osrEmpty;

    assign clkDivInt     = clkDiv[clkDivIntMsb:clkDivIntLsb];
    assign inShiftRight  = shiftCtrl[inShiftRightBit];
    assign outShiftRight = shiftCtrl[outShiftRightBit];

    clockDivider clockDivider_inst (
        .clk       (clk),
        .reset     (reset),
        .clkDivInt (clkDivInt),
        .restart   (clkDivRestart),
        .tick      (tick)
    );

    inputShiftReg inputShiftReg_inst (
        .clk        (clk),
        .reset      (reset),
        .shiftRight (inShiftRight),
        .shiftEn    (isrShiftEn),
        .shiftLen   (isrShiftLen),
        .shiftData  (isrShiftData),
        .clear      (isrClear),
        .isrData    (isrData),
        .isrFull    (isrFull)
    );

    outputShiftReg outputShiftReg_inst (
        .clk        (clk),
        .reset      (reset),
        .shiftRight (outShiftRight),
        .shiftEn    (osrShiftEn),
        .shiftLen   (osrShiftLen),
        .loadEn     (osrLoadEn),
        .loadData   (osrLoadData),
        .osrData    (osrData),
        .osrEmpty   (osrEmpty)
    );

    executionUnit executionUnit_inst (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .smEnable     (smEnable),
        .opCode       (opCode),
        .execCtrl     (execCtrl),
        .gpioIn       (gpioIn),
        .txData       (txData),
        .txEmpty      (txEmpty),
        .rxFull       (rxFull),
        .isrData      (isrData),
        .isrFull      (isrFull),
        .osrData      (osrData),
        .osrEmpty     (osrEmpty),
        .pc           (pc),
        .txAck        (txAck),
        .rxData       (rxData),
        .rxValid      (rxValid),
        .pinWrite     (pinWrite),
        .pinIsDir     (pinIsDir),
        .pinData      (pinData),
        .isrShiftEn   (isrShiftEn),
        .isrShiftLen  (isrShiftLen),
        .isrShiftData (isrShiftData),
        .isrClear     (isrClear),
        .osrShiftEn   (osrShiftEn),
        .osrShiftLen  (osrShiftLen),
        .osrLoadEn    (osrLoadEn),
        .osrLoadData  (osrLoadData)
    );

endmodule

/* shifter/inputShiftReg.sv */
// Input shift register collecting IN data with a saturating bit count
`timescale 1ns/1ps

module inputShiftReg import pioPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      shiftRight,
    input  logic      shiftEn,
    input  bitCount_t shiftLen,
    input  word_t     shiftData,
    input  logic      clear,
    output word_t     isrData,
    output logic      isrFull
);

    logic [5:0] shiftAmt;   // 1 to 32
    logic [5:0] fillAmt;    // Remaining width, 0 to 31
    logic [5:0] bitCount;
    logic [6:0] countSum;
    word_t      lowMask;
    word_t      shiftedData;

    assign shiftAmt = (shiftLen == '0) ? 6'd32 : {1'b0, shiftLen};
    assign fillAmt  = 6'd32 - shiftAmt;
    assign lowMask  = ~(32'hFFFF_FFFF << shiftAmt);

    always_comb begin
        if (shiftRight) begin
            // New bits enter from the MSB end
            shiftedData = (isrData >> shiftAmt) | (shiftData << fillAmt);
        end else begin
            shiftedData = (isrData << shiftAmt) | (shiftData & lowMask);
        end
    end

    assign countSum = {1'b0, bitCount} + {1'b0, shiftAmt};
    assign isrFull  = (bitCount >= 6'(shiftFullCount));

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            isrData  <= '0;
            bitCount <= '0;
        end else if (clear) begin
            isrData  <= '0;  // Push empties the register
            bitCount <= '0;
        end else if (shiftEn) begin
            isrData <= shiftedData;
            if (countSum > 7'(shiftFullCount)) begin
                bitCount <= 6'(shiftFullCount);
            end else begin
                bitCount <= countSum[5:0];
            end
        end
    end

endmodule

/* shifter/outputShiftReg.sv */
// Output shift register feeding OUT with the next bits of the pulled word
`timescale 1ns/1ps

module outputShiftReg import pioPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      shiftRight,
    input  logic      shiftEn,
    input  bitCount_t shiftLen,
    input  logic      loadEn,
    input  word_t     loadData,
    output word_t     osrData,
    output logic      osrEmpty
);

    word_t      osrWord;
    logic [5:0] shiftAmt;   // 1 to 32
    logic [5:0] fillAmt;
    logic [5:0] bitCount;   // Bits already shifted out
    logic [6:0] countSum;
    word_t      lowMask;

    assign shiftAmt = (shiftLen == '0) ? 6'd32 : {1'b0, shiftLen};
    assign fillAmt  = 6'd32 - shiftAmt;
    assign lowMask  = ~(32'hFFFF_FFFF << shiftAmt);

    // Next shiftLen bits, right-aligned with zeros above
    assign osrData = shiftRight ? (osrWord & lowMask) : (osrWord >> fillAmt);

    assign countSum = {1'b0, bitCount} + {1'b0, shiftAmt};
    assign osrEmpty = (bitCount >= 6'(shiftFullCount));

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            osrWord  <= '0;
            bitCount <= 6'(shiftFullCount);  // Nothing pulled yet
        end else if (loadEn) begin
            osrWord  <= loadData;
            bitCount <= '0;
        end else if (shiftEn) begin
            if (shiftRight) begin
                osrWord <= osrWord >> shiftAmt;
            end else begin
                osrWord <= osrWord << shiftAmt;
            end
            if (countSum > 7'(shiftFullCount)) begin
                bitCount <= 6'(shiftFullCount);
            end else begin
                bitCount <= countSum[5:0];
            end
        end
    end

endmodule

/* tb/pioStateMachine_checker.sv */
// Bound assertions on PIO FIFO handshakes and program counter wrap
`timescale 1ns/1ps

module pioStateMachine_checker import pioPkg::*; import pioCfgPkg::*; (
    input logic    clk,
    input logic    reset,
    input logic    tick,
    input logic    smEnable,
    input opcode_t opCode,
    input word_t   execCtrl,
    input word_t   osrData,
    input logic    txEmpty,
    input logic    rxFull,
    input logic    txAck,
    input logic    rxValid,
    input pcAddr_t pc
);

    int      failCount = 0;  // Failed assertions so far
    logic    execTick;
    pcAddr_t wrapTop;
    pcAddr_t wrapBottom;
    logic    isJmp;
    logic    isOutPc;

    assign execTick   = tick && smEnable;
    assign wrapTop    = execCtrl[wrapTopMsb:wrapTopLsb];
    assign wrapBottom = execCtrl[wrapBottomMsb:wrapBottomLsb];
    assign isJmp      = (opCode[opMsb:opLsb] == opJmp);
    assign isOutPc    = (opCode[opMsb:opLsb] == opOut) && (opCode[condMsb:condLsb] == 3'b101);

    // Ack only after a tick that found data
    txAckAfterData: assert property (@(posedge clk) disable iff (!reset)
        txAck |-> $past(execTick && !txEmpty))
        else begin
            failCount++;
            $error("txAck raised without a tick that saw TX data");
        end

    rxValidAfterSpace: assert property (@(posedge clk) disable iff (!reset)
        rxValid |-> $past(execTick && !rxFull))
        else begin
            failCount++;
            $error("rxValid raised without a tick that saw RX space");
        end

    // Leaving wrapTop goes to wrapBottom or to a jump target
    wrapTopExit: assert property (@(posedge clk) disable iff (!reset)
        ($past(pc == wrapTop) && pc != $past(pc)) |->
            (pc == $past(wrapBottom)
             || ($past(isJmp) && pc == $past(opCode[dataMsb:dataLsb]))
             || ($past(isOutPc) && pc == $past(osrData[4:0]))))
        else begin
            failCount++;
            $error("pc left wrapTop to an address other than wrapBottom or a target");
        end

endmodule

bind pioStateMachine pioStateMachine_checker checkerInst (
    .clk      (clk),
    .reset    (reset),
    .tick     (tick),
    .smEnable (smEnable),
    .opCode   (opCode),
    .execCtrl (execCtrl),
    .osrData  (osrData),
    .txEmpty  (txEmpty),
    .rxFull   (rxFull),
    .txAck    (txAck),
    .rxValid  (rxValid),
    .pc       (pc)
);

/* tb/pioStateMachine_tb.sv */
// Testbench for the PIO state machine with program memory and FIFO models
`timescale 1ns/1ps

module pioStateMachine_tb import pioPkg::*; import pioCfgPkg::*; ();

    localparam int clkPeriod      = 100;
    localparam int totalProgLen   = 13;  // Words over all five test programs
    localparam int maxClkDiv      = 3;
    localparam int watchdogCycles = (totalProgLen * maxClkDiv + 100) * 4;

    // Condition, source and destination codes
    localparam int condAlways  = 0;
    localparam int condXDec    = 2;
    localparam int condPin     = 6;
    localparam int destPins    = 0;
    localparam int destX       = 1;
    localparam int destPinDirs = 4;
    localparam int srcPins     = 0;
    localparam int pullBlock   = 3'b101;
    localparam int pushBlock   = 3'b001;
    localparam int waitHigh    = 3'b100;  // Polarity 1, GPIO source
    localparam int waitBit     = 4;
    localparam int bodyDelay   = 2;

    logic    clk;
    logic    reset;
    logic    smEnable;
    logic    clkDivRestart;
    word_t   clkDiv;
    word_t   execCtrl;
    word_t   shiftCtrl;
    opcode_t opCode;
    word_t   gpioIn;
    word_t   txData;
    logic    txEmpty;
    logic    rxFull;
    pcAddr_t pc;
    logic    txAck;
    word_t   rxData;
    logic    rxValid;
    logic    pinWrite;
    logic    pinIsDir;
    word_t   pinData;

    opcode_t progMem [32];
    word_t   txQueue[$];
    word_t   rxQueue[$];
    word_t   pinDataLog[$];
    logic    pinDirLog[$];
    int      pinCycleLog[$];
    pcAddr_t pcLog[$];
    int      pcCycleLog[$];
    pcAddr_t lastPc;
    int      cycle = 0;
    int      ackCount;
    int      seed = 78649;
    word_t   randWord;

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    assign opCode = progMem[pc];  // Program memory read in the same cycle

    pioStateMachine pioStateMachine_inst (
        .clk           (clk),
        .reset         (reset),
        .smEnable      (smEnable),
        .clkDivRestart (clkDivRestart),
        .clkDiv        (clkDiv),
        .execCtrl      (execCtrl),
        .shiftCtrl     (shiftCtrl),
        .opCode        (opCode),
        .gpioIn        (gpioIn),
        .txData        (txData),
        .txEmpty       (txEmpty),
        .rxFull        (rxFull),
        .pc            (pc),
        .txAck         (txAck),
        .rxData        (rxData),
        .rxValid       (rxValid),
        .pinWrite      (pinWrite),
        .pinIsDir      (pinIsDir),
        .pinData       (pinData)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string testName, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            abortRun($sformatf("Mismatch in %s: expected 0x%08h, actual 0x%08h",
                               testName, expected, actual));
        end
    endtask

    function automatic opcode_t encodeInstr(input instrOp_e op, input int delay,
                                            input int cond, input int data);
        return {op, 5'(delay), 3'(cond), 5'(data)};
    endfunction

    // TX FIFO shows its head word
    always @(posedge clk) begin
        txEmpty <= (txQueue.size() == 0);
        txData  <= (txQueue.size() == 0) ? '0 : txQueue[0];
    end

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (reset) begin
            if (pinWrite) begin
                pinDataLog.push_back(pinData);
                pinDirLog.push_back(pinIsDir);
                pinCycleLog.push_back(cycle);
            end
            if (txAck && txQueue.size() > 0) begin
                txQueue.delete(0);
                ackCount = ackCount + 1;
            end
            if (rxValid) rxQueue.push_back(rxData);
            if (pc != lastPc) begin
                pcLog.push_back(pc);
                pcCycleLog.push_back(cycle);
                lastPc = pc;
            end
        end
        assert (pioStateMachine_inst.checkerInst.failCount == 0)
            else abortRun("A bound handshake or PC assertion failed");
    end

    task automatic beginReset(input int divInt, input int pin, input int top, input int bottom,
                              input word_t shiftWord);
        @(posedge clk);
        reset         <= 1'b0;
        smEnable      <= 1'b0;
        clkDivRestart <= 1'b0;
        gpioIn        <= '0;
        rxFull        <= 1'b0;
        clkDiv        <= word_t'(divInt) << clkDivIntLsb;
        execCtrl      <= (word_t'(pin) << jmpPinLsb) | (word_t'(top) << wrapTopLsb)
                         | (word_t'(bottom) << wrapBottomLsb);
        shiftCtrl     <= shiftWord;
        foreach (progMem[i]) progMem[i] = encodeInstr(opJmp, 0, condAlways, i);  // Jump to self
        txQueue.delete();
        rxQueue.delete();
        pinDataLog.delete();
        pinDirLog.delete();
        pinCycleLog.delete();
        pcLog.delete();
        pcCycleLog.delete();
        lastPc   = '0;
        ackCount = 0;
    endtask

    task automatic endReset();
        repeat (4) @(posedge clk);
        reset    <= 1'b1;
        smEnable <= 1'b1;
    endtask

    task automatic waitForPc(input pcAddr_t target);
        while (pc !== target) @(negedge clk);
        @(negedge clk);  // Monitor has logged the new pc by now
    endtask

    task automatic waitForPinWrites(input int count);
        while (pinDataLog.size() < count) @(negedge clk);
    endtask

    initial begin
        reset         <= 1'b0;
        smEnable      <= 1'b0;
        clkDivRestart <= 1'b0;
        clkDiv        <= '0;
        execCtrl      <= '0;
        shiftCtrl     <= '0;
        gpioIn        <= '0;
        rxFull        <= 1'b0;
        txEmpty       <= 1'b1;
        txData        <= '0;
        foreach (progMem[i]) progMem[i] = '0;  // JMP 0 until a program is loaded

        // SET to pins, pindirs and X inside a 0..2 wrap
        beginReset(1, 0, 2, 0, '0);
        progMem[0] = encodeInstr(opSet, 0, destPins, 5);
        progMem[1] = encodeInstr(opSet, 0, destPinDirs, 3);
        progMem[2] = encodeInstr(opSet, 0, destX, 7);
        endReset();
        waitForPinWrites(2);
        while (pcLog.size() < 3) @(negedge clk);
        checkValue("setWrap pins data", 5, pinDataLog[0]);
        checkValue("setWrap pins dir", 0, pinDirLog[0]);
        checkValue("setWrap pindirs data", 3, pinDataLog[1]);
        checkValue("setWrap pindirs dir", 1, pinDirLog[1]);
        checkValue("setWrap pc step 1", 1, pcLog[0]);
        checkValue("setWrap pc step 2", 2, pcLog[1]);
        checkValue("setWrap pc wrap", 0, pcLog[2]);

        // X-- loop, taken while X is nonzero before the decrement
        beginReset(1, 0, 31, 0, '0);
        progMem[0] = encodeInstr(opSet, 0, destX, 3);
        progMem[1] = encodeInstr(opSet, bodyDelay, destPins, 1);
        progMem[2] = encodeInstr(opJmp, 0, condXDec, 1);
        endReset();
        waitForPc(3);
        checkValue("jmpLoop pin writes", 3 + 1, pinDataLog.size());
        for (int i = 1; i < 4; i++) begin
            // Body tick, delay idle ticks, then the jump
            checkValue("jmpLoop write spacing", 1 + bodyDelay + 1,
                       pinCycleLog[i] - pinCycleLog[i - 1]);
        end

        // Blocking PULL stalls on an empty TX FIFO
        beginReset(1, 0, 31, 0, word_t'(1) << outShiftRightBit);
        progMem[0] = encodeInstr(opPushPull, 0, pullBlock, 0);
        progMem[1] = encodeInstr(opOut, 0, destPins, 8);
        progMem[2] = encodeInstr(opOut, 0, destPins, 8);
        endReset();
        repeat (10) @(negedge clk);
        checkValue("pullOut stalled pc", 0, pc);
        checkValue("pullOut stalled ack", 0, ackCount);
        randWord = $random(seed);
        txQueue.push_back(randWord);
        waitForPinWrites(2);
        checkValue("pullOut low byte", randWord[7:0], pinDataLog[0]);
        checkValue("pullOut next byte", randWord[15:8], pinDataLog[1]);
        waitForPc(3);
        checkValue("pullOut ack count", 1, ackCount);

        // IN 32 from pins then a blocking PUSH against a full RX FIFO
        beginReset(1, 0, 31, 0, '0);
        progMem[0] = encodeInstr(opIn, 0, srcPins, 0);  // Count 0 shifts 32 bits
        progMem[1] = encodeInstr(opPushPull, 0, pushBlock, 0);
        randWord = $random(seed);
        gpioIn <= randWord;
        rxFull <= 1'b1;
        endReset();
        waitForPc(1);
        repeat (10) @(negedge clk);
        checkValue("inPush stalled pc", 1, pc);
        checkValue("inPush stalled rx", 0, rxQueue.size());
        @(posedge clk);
        rxFull <= 1'b0;
        while (rxQueue.size() < 1) @(negedge clk);
        checkValue("inPush rx word", randWord, rxQueue[0]);

        // WAIT on GPIO 4 then JMP PIN at divider 3
        beginReset(maxClkDiv, waitBit, 31, 0, '0);
        progMem[0] = encodeInstr(opWait, 0, waitHigh, waitBit);
        progMem[1] = encodeInstr(opJmp, 0, condPin, 5);
        endReset();
        @(posedge clk);
        clkDivRestart <= 1'b1;
        @(posedge clk);
        clkDivRestart <= 1'b0;
        repeat (20) @(negedge clk);
        checkValue("waitPin held pc", 0, pc);
        @(posedge clk);
        gpioIn <= word_t'(1) << waitBit;
        waitForPc(5);
        checkValue("waitPin pc changes", 2, pcLog.size());
        checkValue("waitPin after wait", 1, pcLog[0]);
        checkValue("waitPin jump target", 5, pcLog[1]);
        checkValue("waitPin tick spacing", maxClkDiv, pcCycleLog[1] - pcCycleLog[0]);

        repeat (2) @(negedge clk);
        if (pioStateMachine_inst.checkerInst.failCount != 0) begin
            abortRun("Bound assertions failed during the run");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

    // Watchdog
    initial begin
        #(watchdogCycles * clkPeriod);
        abortRun($sformatf("Timeout after %0d cycles without finishing", watchdogCycles));
    end

endmodule

/* verilog.f */
common/pioPkg.sv
common/pioCfgPkg.sv
design/clockDivider.sv
shifter/inputShiftReg.sv
shifter/outputShiftReg.sv
design/executionUnit.sv
design/pioStateMachine.sv
tb/pioStateMachine_checker.sv
tb/pioStateMachine_tb.sv
